// File: Makefile
VERILATOR ?= verilator
TOP       ?= issue_subsystem_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: common/issue_macros.svh
/*
 * issue stage sizing
 * tag widths and queue, dispatch, issue and writeback widths
 */
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// physical register tag, 64 registers
`define PRF_INDEX_SIZE 6

// integer issue queue slots
`define IQ_INT_SIZE 8

// micro-ops accepted from dispatch per cycle
`define DISPATCH_WIDTH 2

// pipes 0 and 1 for alu/branch, pipe 2 for mul/div
`define ISSUE_WIDTH_INT 3

// writeback ports clearing busy bits
`define WB_WIDTH 3

`endif

// File: common/issue_pkg.sv
/*
 * issue stage types
 * micro-op layout, operand2 views and unit/source encodings
 */
`include "issue_macros.svh"

package issue_pkg;

  typedef enum logic [1:0] {
    FU_ALU  = 2'd0,
    FU_BR   = 2'd1,
    FU_IMUL = 2'd2,
    FU_IDIV = 2'd3
  } fu_code_t;

  // rs1 from an immediate reads as zero
  typedef enum logic {
    RS_FROM_RF  = 1'b0,
    RS_FROM_IMM = 1'b1
  } rs_source_t;

  // register view of the second operand word
  typedef struct packed {
    logic [11-`PRF_INDEX_SIZE:0] unused;
    logic [`PRF_INDEX_SIZE-1:0]  tag;
  } op2_reg_t;

  // same 12 bits, either a tag or an immediate
  typedef union packed {
    op2_reg_t    rf;
    logic [11:0] imm;
  } operand2_u;

  typedef struct packed {
    logic                       valid;
    fu_code_t                   fu_code;
    logic [`PRF_INDEX_SIZE-1:0] rd_prf;
    rs_source_t                 rs1_source;
    logic [`PRF_INDEX_SIZE-1:0] rs1_prf;
    rs_source_t                 rs2_source;
    operand2_u                  op2;
    logic [3:0]                 rob_tag;
  } micro_op_t;

endpackage

// File: issue_queue/issue_queue_int.sv
/*
 * integer issue queue
 * eight slots, two-lane dispatch allocation, three issue pipes
 * pipes 0/1 take alu and branch ops, the last pipe takes mul/div
 */
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_queue_int (
  input  logic                                             clock,
  input  logic                                             rst,
  input  logic                                             flush,
  input  issue_pkg::micro_op_t [`DISPATCH_WIDTH-1:0]       dispatch_uop,
  input  logic [`IQ_INT_SIZE-1:0]                          rs1_busy,
  input  logic [`IQ_INT_SIZE-1:0]                          rs2_busy,
  output logic [`IQ_INT_SIZE-1:0][`PRF_INDEX_SIZE-1:0]     rs1_index,
  output logic [`IQ_INT_SIZE-1:0][`PRF_INDEX_SIZE-1:0]     rs2_index,
  output issue_pkg::micro_op_t [`ISSUE_WIDTH_INT-1:0]      issue_uop,
  output logic                                             iq_full,
  output logic [`DISPATCH_WIDTH-1:0]                       dispatch_accept
);

  localparam int IDX_W     = $clog2(`IQ_INT_SIZE);
  localparam int CNT_W     = IDX_W + 1;
  localparam int ALU_PIPES = `ISSUE_WIDTH_INT - 1;

  logic [CNT_W-1:0] free_count_q;
  logic [CNT_W-1:0] in_count;
  logic [CNT_W-1:0] out_count;

  logic [`IQ_INT_SIZE-1:0] free;
  logic [`IQ_INT_SIZE-1:0] ready;
  logic [`IQ_INT_SIZE-1:0] ready_alu_br;
  logic [`IQ_INT_SIZE-1:0] ready_mul_div;
  logic [`IQ_INT_SIZE-1:0] load;
  logic [`IQ_INT_SIZE-1:0] issue_clear;

  issue_pkg::micro_op_t [`IQ_INT_SIZE-1:0] uop_to_slot;
  issue_pkg::micro_op_t [`IQ_INT_SIZE-1:0] slot_uop;

  logic [`DISPATCH_WIDTH-1:0][IDX_W-1:0] in_sel;
  logic [`DISPATCH_WIDTH-1:0]            in_sel_valid;
  logic [ALU_PIPES-1:0][IDX_W-1:0]       alu_sel;
  logic [ALU_PIPES-1:0]                  alu_sel_valid;
  logic [0:0][IDX_W-1:0]                 md_sel;
  logic [0:0]                            md_sel_valid;

  // full means fewer free slots than dispatch lanes
  assign iq_full = free_count_q < CNT_W'(`DISPATCH_WIDTH);

  for (genvar k = 0; k < `IQ_INT_SIZE; k++) begin : g_slot
    issue_slot_int u_slot (
      .clock     (clock),
      .rst       (rst),
      .clear     (issue_clear[k] || flush),
      .load      (load[k]),
      .uop_in    (uop_to_slot[k]),
      .rs1_busy  (rs1_busy[k]),
      .rs2_busy  (rs2_busy[k]),
      .uop       (slot_uop[k]),
      .rs1_index (rs1_index[k]),
      .rs2_index (rs2_index[k]),
      .ready     (ready[k]),
      .free      (free[k])
    );

    assign ready_alu_br[k]  = ready[k] && (slot_uop[k].fu_code == issue_pkg::FU_ALU ||
                                           slot_uop[k].fu_code == issue_pkg::FU_BR);
    assign ready_mul_div[k] = ready[k] && (slot_uop[k].fu_code == issue_pkg::FU_IMUL ||
                                           slot_uop[k].fu_code == issue_pkg::FU_IDIV);
  end

  // lane i goes to the i-th lowest free slot
  issue_queue_int_selector #(.REQS(`DISPATCH_WIDTH), .WIDTH(`IQ_INT_SIZE)) u_in_sel (
    .ready     (free),
    .sel       (in_sel),
    .sel_valid (in_sel_valid)
  );

  for (genvar i = 0; i < `DISPATCH_WIDTH; i++) begin : g_accept
    assign dispatch_accept[i] = dispatch_uop[i].valid && !iq_full && !flush && in_sel_valid[i];
  end

  always_comb begin
    load        = '0;
    uop_to_slot = '0;
    in_count    = '0;
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      if (dispatch_accept[i]) begin
        load[in_sel[i]]        = 1'b1;
        uop_to_slot[in_sel[i]] = dispatch_uop[i];
        in_count               = in_count + 1'b1;
      end
    end
  end

  issue_queue_int_selector #(.REQS(ALU_PIPES), .WIDTH(`IQ_INT_SIZE)) u_alu_br_sel (
    .ready     (ready_alu_br),
    .sel       (alu_sel),
    .sel_valid (alu_sel_valid)
  );

  issue_queue_int_selector #(.REQS(1), .WIDTH(`IQ_INT_SIZE)) u_mul_div_sel (
    .ready     (ready_mul_div),
    .sel       (md_sel),
    .sel_valid (md_sel_valid)
  );

  // issued slots empty at the next edge, pipes never stall
  always_comb begin
    issue_uop   = '0;
    issue_clear = '0;
    out_count   = '0;
    for (int p = 0; p < ALU_PIPES; p++) begin
      if (alu_sel_valid[p]) begin
        issue_uop[p]         = slot_uop[alu_sel[p]];
        issue_clear[alu_sel[p]] = 1'b1;
        out_count            = out_count + 1'b1;
      end
    end
    if (md_sel_valid[0]) begin
      issue_uop[ALU_PIPES]   = slot_uop[md_sel[0]];
      issue_clear[md_sel[0]] = 1'b1;
      out_count              = out_count + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (rst || flush) begin
      free_count_q <= CNT_W'(`IQ_INT_SIZE);
    end else begin
      free_count_q <= free_count_q - in_count + out_count;
    end
  end

  // running count must track the slot valid bits
  a_free_count: assert property (@(posedge clock) disable iff (rst)
    free_count_q == CNT_W'($countones(free)));

endmodule

// File: issue_queue/issue_queue_int_selector.sv
/*
 * issue queue selector
 * picks the REQS lowest set bits of a request vector, in order
 */
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_queue_int_selector #(
  parameter int REQS  = `DISPATCH_WIDTH,
  parameter int WIDTH = `IQ_INT_SIZE
) (
  input  logic [WIDTH-1:0]                    ready,
  output logic [REQS-1:0][$clog2(WIDTH)-1:0] sel,
  output logic [REQS-1:0]                     sel_valid
);

  always_comb begin
    logic [WIDTH-1:0] remaining;

    remaining = ready;
    for (int i = 0; i < REQS; i++) begin
      sel[i]       = '0;
      sel_valid[i] = 1'b0;
      // scan downward so the lowest set bit wins
      for (int j = WIDTH - 1; j >= 0; j--) begin
        if (remaining[j]) begin
          sel[i]       = ($clog2(WIDTH))'(j);
          sel_valid[i] = 1'b1;
        end
      end
      // mask off this pick for the next request
      if (sel_valid[i]) begin
        remaining[sel[i]] = 1'b0;
      end
    end
  end

endmodule

// File: issue_queue/issue_slot_int.sv
/*
 * integer issue slot
 * holds one micro-op, exposes its source tags, reports ready and free
 */
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_slot_int (
  input  logic                       clock,
  input  logic                       rst,
  input  logic                       clear,
  input  logic                       load,
  input  issue_pkg::micro_op_t       uop_in,
  input  logic                       rs1_busy,
  input  logic                       rs2_busy,
  output issue_pkg::micro_op_t       uop,
  output logic [`PRF_INDEX_SIZE-1:0] rs1_index,
  output logic [`PRF_INDEX_SIZE-1:0] rs2_index,
  output logic                       ready,
  output logic                       free
);

  logic                 valid_q;
  issue_pkg::micro_op_t payload_q;

  always_ff @(posedge clock) begin
    if (rst || clear) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= uop_in.valid;
    end
  end

  // payload only moves on load
  always_ff @(posedge clock) begin
    if (load) begin
      payload_q <= uop_in;
    end
  end

  always_comb begin
    uop       = payload_q;
    uop.valid = valid_q;
  end

  // tag 0 stands for a non-register source
  assign rs1_index = (payload_q.rs1_source == issue_pkg::RS_FROM_RF) ? payload_q.rs1_prf : '0;
  assign rs2_index = (payload_q.rs2_source == issue_pkg::RS_FROM_RF) ?
                     payload_q.op2.rf.tag : '0;

  assign ready = valid_q && !rs1_busy && !rs2_busy;
  assign free  = !valid_q;

  // queue must never issue from a slot it is filling
  a_load_clear_excl: assert property (@(posedge clock) disable iff (rst) !(load && clear));

endmodule

// File: rtl/busy_table.sv
/*
 * physical register busy table
 * set on dispatch, cleared on writeback, read per queue slot
 */
`timescale 1ns/1ps
`include "issue_macros.svh"

module busy_table (
  input  logic                                           clock,
  input  logic                                           rst,
  input  logic                                           flush,
  input  logic [`DISPATCH_WIDTH-1:0]                     set_valid,
  input  logic [`DISPATCH_WIDTH-1:0][`PRF_INDEX_SIZE-1:0] set_tag,
  input  logic [`WB_WIDTH-1:0]                           wb_valid,
  input  logic [`WB_WIDTH-1:0][`PRF_INDEX_SIZE-1:0]      wb_tag,
  input  logic [`IQ_INT_SIZE-1:0][`PRF_INDEX_SIZE-1:0]   rs1_index,
  input  logic [`IQ_INT_SIZE-1:0][`PRF_INDEX_SIZE-1:0]   rs2_index,
  output logic [`IQ_INT_SIZE-1:0]                        rs1_busy,
  output logic [`IQ_INT_SIZE-1:0]                        rs2_busy
);

  localparam int NUM_PRF = 1 << `PRF_INDEX_SIZE;

  logic [NUM_PRF-1:0] busy_q;
  logic [NUM_PRF-1:0] busy_next;

  always_comb begin
    busy_next = busy_q;
    for (int w = 0; w < `WB_WIDTH; w++) begin
      if (wb_valid[w]) begin
        busy_next[wb_tag[w]] = 1'b0;
      end
    end
    // a set on the same tag overrides writeback
    for (int d = 0; d < `DISPATCH_WIDTH; d++) begin
      if (set_valid[d]) begin
        busy_next[set_tag[d]] = 1'b1;
      end
    end
    busy_next[0] = 1'b0;
  end

  always_ff @(posedge clock) begin
    if (rst || flush) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_next;
    end
  end

  for (genvar k = 0; k < `IQ_INT_SIZE; k++) begin : g_read
    assign rs1_busy[k] = busy_q[rs1_index[k]];
    assign rs2_busy[k] = busy_q[rs2_index[k]];
  end

  // x0 is never a writeback target
  for (genvar w = 0; w < `WB_WIDTH; w++) begin : g_wb_chk
    a_wb_tag_nonzero: assert property (@(posedge clock) disable iff (rst)
      wb_valid[w] |-> wb_tag[w] != '0);
  end

endmodule

// File: rtl/issue_subsystem.sv
/*
 * integer issue subsystem
 * joins the integer issue queue with the busy table
 */
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_subsystem (
  input  logic                                        clock,
  input  logic                                        rst,
  input  logic                                        flush,
  input  issue_pkg::micro_op_t [`DISPATCH_WIDTH-1:0]  dispatch_uop,
  input  logic [`WB_WIDTH-1:0]                        wb_valid,
  input  logic [`WB_WIDTH-1:0][`PRF_INDEX_SIZE-1:0]   wb_tag,
  output logic                                        iq_full,
  output issue_pkg::micro_op_t [`ISSUE_WIDTH_INT-1:0] issue_uop
);

  logic [`IQ_INT_SIZE-1:0][`PRF_INDEX_SIZE-1:0]    rs1_index;
  logic [`IQ_INT_SIZE-1:0][`PRF_INDEX_SIZE-1:0]    rs2_index;
  logic [`IQ_INT_SIZE-1:0]                         rs1_busy;
  logic [`IQ_INT_SIZE-1:0]                         rs2_busy;
  logic [`DISPATCH_WIDTH-1:0]                      dispatch_accept;
  logic [`DISPATCH_WIDTH-1:0][`PRF_INDEX_SIZE-1:0] set_tag;

  // destination tags of the dispatch lanes
  for (genvar i = 0; i < `DISPATCH_WIDTH; i++) begin : g_set_tag
    assign set_tag[i] = dispatch_uop[i].rd_prf;
  end

  issue_queue_int u_iq (
    .clock           (clock),
    .rst             (rst),
    .flush           (flush),
    .dispatch_uop    (dispatch_uop),
    .rs1_busy        (rs1_busy),
    .rs2_busy        (rs2_busy),
    .rs1_index       (rs1_index),
    .rs2_index       (rs2_index),
    .issue_uop       (issue_uop),
    .iq_full         (iq_full),
    .dispatch_accept (dispatch_accept)
  );

  // set only for lanes the queue took
  busy_table u_busy (
    .clock     (clock),
    .rst       (rst),
    .flush     (flush),
    .set_valid (dispatch_accept),
    .set_tag   (set_tag),
    .wb_valid  (wb_valid),
    .wb_tag    (wb_tag),
    .rs1_index (rs1_index),
    .rs2_index (rs2_index),
    .rs1_busy  (rs1_busy),
    .rs2_busy  (rs2_busy)
  );

endmodule

// File: sim.f
+incdir+common
common/issue_pkg.sv
issue_queue/issue_slot_int.sv
issue_queue/issue_queue_int_selector.sv
issue_queue/issue_queue_int.sv
rtl/busy_table.sv
rtl/issue_subsystem.sv
verification/issue_subsystem_tb.sv

// File: verification/issue_subsystem_tb.sv
/*
 * integer issue subsystem testbench
 * table of dispatch, writeback and flush steps with expected issue lanes
 */
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_subsystem_tb;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;

  typedef logic [`PRF_INDEX_SIZE-1:0] tag_t;

  typedef struct {
    string                                       name;
    issue_pkg::micro_op_t [`DISPATCH_WIDTH-1:0]  disp;
    logic [`WB_WIDTH-1:0]                        wb_valid;
    tag_t [`WB_WIDTH-1:0]                        wb_tag;
    logic                                        flush;
    logic                                        exp_full;
    issue_pkg::micro_op_t [`ISSUE_WIDTH_INT-1:0] exp_issue;
  } step_t;

  logic                                        clock;
  logic                                        rst;
  logic                                        flush;
  issue_pkg::micro_op_t [`DISPATCH_WIDTH-1:0]  dispatch_uop;
  logic [`WB_WIDTH-1:0]                        wb_valid;
  logic [`WB_WIDTH-1:0][`PRF_INDEX_SIZE-1:0]   wb_tag;
  logic                                        iq_full;
  issue_pkg::micro_op_t [`ISSUE_WIDTH_INT-1:0] issue_uop;

  step_t steps[$];
  int    errors;
  int    checks;
  bit    table_ready;

  issue_subsystem u_dut (
    .clock        (clock),
    .rst          (rst),
    .flush        (flush),
    .dispatch_uop (dispatch_uop),
    .wb_valid     (wb_valid),
    .wb_tag       (wb_tag),
    .iq_full      (iq_full),
    .issue_uop    (issue_uop)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  function automatic issue_pkg::micro_op_t make_uop(
    input issue_pkg::fu_code_t   fu,
    input logic [3:0]            rob,
    input tag_t                  rd,
    input issue_pkg::rs_source_t s1,
    input tag_t                  rs1,
    input issue_pkg::rs_source_t s2,
    input logic [11:0]           op2
  );
    issue_pkg::micro_op_t u;
    u            = '0;
    u.valid      = 1'b1;
    u.fu_code    = fu;
    u.rd_prf     = rd;
    u.rs1_source = s1;
    u.rs1_prf    = rs1;
    u.rs2_source = s2;
    u.op2.imm    = op2;
    u.rob_tag    = rob;
    return u;
  endfunction

  // alu op with both sources from registers
  function automatic issue_pkg::micro_op_t alu_rr(
    input logic [3:0] rob,
    input tag_t       rd,
    input tag_t       rs1,
    input tag_t       rs2
  );
    return make_uop(issue_pkg::FU_ALU, rob, rd, issue_pkg::RS_FROM_RF, rs1,
                    issue_pkg::RS_FROM_RF, 12'(rs2));
  endfunction

  // wb_port below zero means no writeback in this step
  function automatic void add_step(
    input string                name,
    input issue_pkg::micro_op_t d0,
    input issue_pkg::micro_op_t d1,
    input int                   wb_port,
    input tag_t                 wb_t,
    input logic                 fl,
    input logic                 full,
    input issue_pkg::micro_op_t e0,
    input issue_pkg::micro_op_t e1,
    input issue_pkg::micro_op_t e2
  );
    step_t s;
    s.name     = name;
    s.disp[0]  = d0;
    s.disp[1]  = d1;
    s.wb_valid = '0;
    s.wb_tag   = '0;
    if (wb_port >= 0) begin
      s.wb_valid[wb_port] = 1'b1;
      s.wb_tag[wb_port]   = wb_t;
    end
    s.flush        = fl;
    s.exp_full     = full;
    s.exp_issue[0] = e0;
    s.exp_issue[1] = e1;
    s.exp_issue[2] = e2;
    steps.push_back(s);
  endfunction

  // expected lanes of a step show the state left by the earlier steps
  function automatic void build_table();
    issue_pkg::micro_op_t nop, a, b, c, m, d, e, p, q, r, s, g0, g1, h0, h1, k;
    issue_pkg::micro_op_t f [7];
    nop = '0;
    a   = alu_rr(4'd1, 6'd10, 6'd1, 6'd2);
    b   = alu_rr(4'd2, 6'd11, 6'd3, 6'd4);
    c   = make_uop(issue_pkg::FU_ALU, 4'd3, 6'd12, issue_pkg::RS_FROM_RF, 6'd10,
                   issue_pkg::RS_FROM_IMM, 12'd5);
    m   = make_uop(issue_pkg::FU_IMUL, 4'd4, 6'd13, issue_pkg::RS_FROM_RF, 6'd6,
                   issue_pkg::RS_FROM_IMM, 12'd7);
    d   = alu_rr(4'd5, 6'd14, 6'd1, 6'd2);
    e   = alu_rr(4'd6, 6'd15, 6'd3, 6'd4);
    p   = alu_rr(4'd7, 6'd20, 6'd2, 6'd3);
    q   = alu_rr(4'd8, 6'd21, 6'd20, 6'd4);
    // immediate 21 matches a busy tag
    r   = make_uop(issue_pkg::FU_ALU, 4'd9, 6'd22, issue_pkg::RS_FROM_RF, 6'd5,
                   issue_pkg::RS_FROM_IMM, 12'd21);
    s   = alu_rr(4'd10, 6'd23, 6'd5, 6'd21);
    // tag 11 is still pending from the dual issue steps
    for (int i = 0; i < 7; i++) begin
      f[i] = alu_rr(4'(11 + i), 6'(31 + i), 6'd11, 6'd4);
    end
    g0  = alu_rr(4'd3, 6'd39, 6'd1, 6'd2);
    g1  = alu_rr(4'd4, 6'd40, 6'd2, 6'd3);
    h0  = alu_rr(4'd5, 6'd41, 6'd2, 6'd31);
    h1  = make_uop(issue_pkg::FU_ALU, 4'd6, 6'd42, issue_pkg::RS_FROM_RF, 6'd41,
                   issue_pkg::RS_FROM_IMM, 12'd0);
    k   = alu_rr(4'd7, 6'd43, 6'd41, 6'd31);

    add_step("reset_idle", nop, nop, -1, 6'd0, 1'b0, 1'b0, nop, nop, nop);
    add_step("dual_alu_in", a, b, -1, 6'd0, 1'b0, 1'b0, nop, nop, nop);
    add_step("dual_alu_out", c, m, -1, 6'd0, 1'b0, 1'b0, a, b, nop);
    add_step("mul_pipe", d, e, 0, 6'd10, 1'b0, 1'b0, nop, nop, m);
    add_step("third_alu_waits", nop, nop, -1, 6'd0, 1'b0, 1'b0, d, e, nop);
    add_step("third_alu_out", nop, nop, -1, 6'd0, 1'b0, 1'b0, c, nop, nop);
    add_step("dep_in", p, q, -1, 6'd0, 1'b0, 1'b0, nop, nop, nop);
    add_step("dep_producer", nop, nop, -1, 6'd0, 1'b0, 1'b0, p, nop, nop);
    add_step("dep_blocked", nop, nop, -1, 6'd0, 1'b0, 1'b0, nop, nop, nop);
    add_step("dep_writeback", nop, nop, 1, 6'd20, 1'b0, 1'b0, nop, nop, nop);
    add_step("dep_consumer", r, s, -1, 6'd0, 1'b0, 1'b0, q, nop, nop);
    add_step("imm_not_blocked", nop, nop, 2, 6'd21, 1'b0, 1'b0, r, nop, nop);
    add_step("fill_0", f[0], f[1], -1, 6'd0, 1'b0, 1'b0, s, nop, nop);
    add_step("fill_1", f[2], f[3], -1, 6'd0, 1'b0, 1'b0, nop, nop, nop);
    add_step("fill_2", f[4], f[5], -1, 6'd0, 1'b0, 1'b0, nop, nop, nop);
    // one slot stays free, so only iq_full holds off g0
    add_step("fill_3", f[6], nop, -1, 6'd0, 1'b0, 1'b0, nop, nop, nop);
    add_step("full_ignore_0", g0, g1, -1, 6'd0, 1'b0, 1'b1, nop, nop, nop);
    add_step("full_ignore_1", g0, g1, -1, 6'd0, 1'b0, 1'b1, nop, nop, nop);
    add_step("drain_writeback", nop, nop, 0, 6'd11, 1'b0, 1'b1, nop, nop, nop);
    add_step("drain_0", nop, nop, -1, 6'd0, 1'b0, 1'b1, f[0], f[1], nop);
    add_step("drain_1", nop, nop, -1, 6'd0, 1'b0, 1'b0, f[2], f[3], nop);
    add_step("drain_2", nop, nop, -1, 6'd0, 1'b0, 1'b0, f[4], f[5], nop);
    add_step("drain_3", nop, nop, -1, 6'd0, 1'b0, 1'b0, f[6], nop, nop);
    add_step("flush_setup", h0, h1, -1, 6'd0, 1'b0, 1'b0, nop, nop, nop);
    add_step("flush", nop, nop, -1, 6'd0, 1'b1, 1'b0, nop, nop, nop);
    add_step("post_flush_in", k, nop, -1, 6'd0, 1'b0, 1'b0, nop, nop, nop);
    add_step("post_flush_out", nop, nop, -1, 6'd0, 1'b0, 1'b0, k, nop, nop);
    add_step("final_idle", nop, nop, -1, 6'd0, 1'b0, 1'b0, nop, nop, nop);
  endfunction

  task automatic check_uop(
    input string                name,
    input issue_pkg::micro_op_t exp,
    input issue_pkg::micro_op_t act
  );
    checks++;
    if (exp.valid) begin
      if (act !== exp) begin
        errors++;
        $display("ERR %s expected uop %h actual uop %h", name, exp, act);
      end
    end else if (act.valid !== 1'b0) begin
      errors++;
      $display("ERR %s expected valid 0 actual valid %b rob %0d", name, act.valid,
               act.rob_tag);
    end
  endtask

  task automatic check_full(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected iq_full %b actual iq_full %b", name, exp, act);
    end
  endtask

  initial begin
    rst          = 1'b1;
    flush        = 1'b0;
    dispatch_uop = '0;
    wb_valid     = '0;
    wb_tag       = '0;
    errors       = 0;
    checks       = 0;
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #1 rst = 1'b0;

    foreach (steps[n]) begin
      @(posedge clock);
      #1;
      dispatch_uop = steps[n].disp;
      wb_valid     = steps[n].wb_valid;
      wb_tag       = steps[n].wb_tag;
      flush        = steps[n].flush;
      // sample just before the edge that takes these inputs
      #(CLK_PERIOD - 2);
      check_full(steps[n].name, steps[n].exp_full, iq_full);
      for (int pipe = 0; pipe < `ISSUE_WIDTH_INT; pipe++) begin
        check_uop($sformatf("%s pipe%0d", steps[n].name, pipe),
                  steps[n].exp_issue[pipe], issue_uop[pipe]);
      end
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // twice the length of reset plus the table
  initial begin
    wait (table_ready);
    #((steps.size() + RESET_CYCLES) * CLK_PERIOD * 2);
    $display("timeout: the step loop did not finish in time");
    $display("TB FAILED");
    $finish;
  end

endmodule
